/* fxp_arith_unit.f */
logic/fxp_pkg.sv
logic/fxp_resize.sv
logic/fxp_addsub.sv
logic/fxp_mul_pipe.sv
logic/fxp_div_pipe.sv
logic/fxp_result_align.sv
logic/fxp_arith_unit.sv
tb/fxp_arith_checker.sv
tb/tb_fxp_arith_unit.sv

/* logic/fxp_addsub.sv */
// Combinational Q8.8 add/subtract with saturation back to Q8.8
`timescale 1ns/10ps

module fxp_addsub import fxp_pkg::*; (
    input  fxp_t a,
    input  fxp_t b,
    input  logic sub,
    output fxp_t sum,
    output logic overflow
);

    // Q9.8 holds the negation of -128.0
    localparam int EXT_W = FXP_W + 1;
    // One more integer bit for the sum, Q10.8
    localparam int SUM_W = FXP_W + 2;

    logic [EXT_W-1:0] a_ext;
    logic [EXT_W-1:0] b_ext;
    logic [EXT_W-1:0] b_arg;
    logic [SUM_W-1:0] raw_sum;

    assign a_ext = {a[FXP_W-1], a};
    assign b_ext = {b[FXP_W-1], b};

    // Two's complement negate in the wide format
    assign b_arg = sub ? ~b_ext + 1'b1 : b_ext;

    assign raw_sum = {a_ext[EXT_W-1], a_ext} + {b_arg[EXT_W-1], b_arg};

    // Back to Q8.8, no fraction bits dropped here
    fxp_resize #(
        .IN_INT_W   (FXP_INT_W + 2),
        .IN_FRAC_W  (FXP_FRAC_W),
        .OUT_INT_W  (FXP_INT_W),
        .OUT_FRAC_W (FXP_FRAC_W),
        .ROUND_EN   (1'b1)
    ) u_sum_resize (
        .in_value  (raw_sum),
        .out_value (sum),
        .overflow  (overflow)
    );

endmodule

/* logic/fxp_arith_unit.sv */
// Top level of the pipelined Q8.8 arithmetic unit
`timescale 1ns/10ps

module fxp_arith_unit import fxp_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  fxp_t    a,
    input  fxp_t    b,
    input  fxp_op_e op,
    output fxp_t    result,
    output logic    overflow
);

    logic sub;

    fxp_t addsub_value;
    logic addsub_ovf;
    fxp_t mul_value;
    logic mul_ovf;
    fxp_t div_value;
    logic div_ovf;

    // Only subtract flips the add/sub unit
    assign sub = (op == OP_SUB);

    fxp_addsub u_addsub (
        .a        (a),
        .b        (b),
        .sub      (sub),
        .sum      (addsub_value),
        .overflow (addsub_ovf)
    );

    fxp_mul_pipe u_mul (
        .clk      (clk),
        .rstn     (rstn),
        .a        (a),
        .b        (b),
        .product  (mul_value),
        .overflow (mul_ovf)
    );

    fxp_div_pipe u_div (
        .clk      (clk),
        .rstn     (rstn),
        .dividend (a),
        .divisor  (b),
        .quotient (div_value),
        .overflow (div_ovf)
    );

    fxp_result_align u_align (
        .clk          (clk),
        .rstn         (rstn),
        .op           (op),
        .addsub_value (addsub_value),
        .addsub_ovf   (addsub_ovf),
        .mul_value    (mul_value),
        .mul_ovf      (mul_ovf),
        .div_value    (div_value),
        .div_ovf      (div_ovf),
        .result       (result),
        .overflow     (overflow)
    );

endmodule

/* logic/fxp_div_pipe.sv */
// Pipelined restoring divider for Q8.8, with rounding and saturation stages
`timescale 1ns/10ps

module fxp_div_pipe import fxp_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  fxp_t dividend,
    input  fxp_t divisor,
    output fxp_t quotient,
    output logic overflow
);

    // Remainder wide enough for the dividend scaled by 2^8
    typedef logic [2*FXP_W-1:0] rem_t;

    localparam int STEPS = FXP_W;

    fxp_t dvd_mag;
    fxp_t dvs_mag;

    rem_t rem_q  [STEPS+1];
    fxp_t dvs_q  [STEPS+1];
    fxp_t quo_q  [STEPS+1];
    logic sign_q [STEPS+1];

    rem_t             trial [STEPS];
    logic [STEPS-1:0] take;

    logic round_up;
    fxp_t mag_q;
    logic rsign_q;

    assign dvd_mag = dividend[FXP_W-1] ? ~dividend + 1'b1 : dividend;
    assign dvs_mag = divisor[FXP_W-1] ? ~divisor + 1'b1 : divisor;

    // ----------------------------------------
    // Trial subtraction, MSB first
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < STEPS; i++) begin
            trial[i] = rem_t'(dvs_q[i]) << (STEPS - 1 - i);
            // A zero remainder takes no more bits, also covers 0/0
            take[i]  = (rem_q[i] != '0) && (rem_q[i] >= trial[i]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i <= STEPS; i++) begin
                rem_q[i]  <= '0;
                dvs_q[i]  <= '0;
                quo_q[i]  <= '0;
                sign_q[i] <= 1'b0;
            end
        end else begin
            // Stage one, magnitudes and result sign
            rem_q[0]  <= rem_t'({dvd_mag, {FXP_FRAC_W{1'b0}}});
            dvs_q[0]  <= dvs_mag;
            quo_q[0]  <= '0;
            sign_q[0] <= dividend[FXP_W-1] ^ divisor[FXP_W-1];
            // One quotient bit per stage, shifted in from the right
            for (int i = 0; i < STEPS; i++) begin
                rem_q[i+1]  <= take[i] ? rem_q[i] - trial[i] : rem_q[i];
                dvs_q[i+1]  <= dvs_q[i];
                quo_q[i+1]  <= {quo_q[i][FXP_W-2:0], take[i]};
                sign_q[i+1] <= sign_q[i];
            end
        end
    end

    // ----------------------------------------
    // Rounding, ties away from zero
    // ----------------------------------------
    // All ones means the quotient ran past the range, leave it for saturation
    assign round_up = (rem_q[STEPS] != '0)
                   && ((rem_q[STEPS] << 1) >= rem_t'(dvs_q[STEPS]))
                   && (quo_q[STEPS] != '1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mag_q   <= '0;
            rsign_q <= 1'b0;
        end else begin
            mag_q   <= quo_q[STEPS] + fxp_t'(round_up);
            rsign_q <= sign_q[STEPS];
        end
    end

    // ----------------------------------------
    // Sign and saturation
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            quotient <= '0;
            overflow <= 1'b0;
        end else if (rsign_q) begin
            if (mag_q[FXP_W-1]) begin
                // Magnitude of exactly 128.0 is still representable
                quotient <= FXP_MIN;
                overflow <= |mag_q[FXP_W-2:0];
            end else begin
                quotient <= ~mag_q + 1'b1;
                overflow <= 1'b0;
            end
        end else if (mag_q[FXP_W-1]) begin
            quotient <= FXP_MAX;
            overflow <= 1'b1;
        end else begin
            quotient <= mag_q;
            overflow <= 1'b0;
        end
    end

    a_ovf_saturated: assert property (@(posedge clk) disable iff (!rstn)
        overflow |-> (quotient == FXP_MAX || quotient == FXP_MIN))
        else $error("divider overflow with quotient %h", quotient);

    // Nonzero over zero shows up as overflow at the end of the pipeline
    a_div_zero_ovf: assert property (@(posedge clk) disable iff (!rstn)
        (divisor == '0 && dividend != '0) |-> ##(DIV_LAT) overflow)
        else $error("divide by zero not flagged");

endmodule

/* logic/fxp_mul_pipe.sv */
// Two-stage signed Q8.8 multiplier, rounded and saturated to Q8.8
`timescale 1ns/10ps

module fxp_mul_pipe import fxp_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  fxp_t a,
    input  fxp_t b,
    output fxp_t product,
    output logic overflow
);

    prod_t prod_q;
    fxp_t  prod_rnd;
    logic  prod_ovf;

    // Stage one, full Q16.16 product
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_q <= '0;
        end else begin
            prod_q <= $signed(a) * $signed(b);
        end
    end

    fxp_resize #(
        .IN_INT_W   (2 * FXP_INT_W),
        .IN_FRAC_W  (2 * FXP_FRAC_W),
        .OUT_INT_W  (FXP_INT_W),
        .OUT_FRAC_W (FXP_FRAC_W),
        .ROUND_EN   (1'b1)
    ) u_prod_resize (
        .in_value  (prod_q),
        .out_value (prod_rnd),
        .overflow  (prod_ovf)
    );

    // Stage two, rounded result and flag
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            product  <= '0;
            overflow <= 1'b0;
        end else begin
            product  <= prod_rnd;
            overflow <= prod_ovf;
        end
    end

endmodule

/* logic/fxp_pkg.sv */
// Shared package: Q8.8 format widths, pipeline latencies, op codes, saturation limits
package fxp_pkg;

    // ----------------------------------------
    // Number format
    // ----------------------------------------
    localparam int FXP_INT_W  = 8;
    localparam int FXP_FRAC_W = 8;
    localparam int FXP_W      = FXP_INT_W + FXP_FRAC_W;
    localparam int PROD_W     = 2 * FXP_W;

    // ----------------------------------------
    // Pipeline latencies in clock cycles
    // ----------------------------------------
    localparam int MUL_LAT  = 2;
    // Magnitude stage, one stage per quotient bit, round, sign/saturate
    localparam int DIV_LAT  = FXP_W + 3;
    localparam int UNIT_LAT = DIV_LAT;

    // One Q8.8 value
    typedef logic [FXP_W-1:0] fxp_t;
    // Full Q16.16 product
    typedef logic [PROD_W-1:0] prod_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_MUL = 2'b10,
        OP_DIV = 2'b11
    } fxp_op_e;

    // Saturation limits, +127.996 and -128.0
    localparam fxp_t FXP_MAX = 16'h7FFF;
    localparam fxp_t FXP_MIN = 16'h8000;

endpackage

/* logic/fxp_resize.sv */
// Signed fixed-point width conversion with round-half-up and saturation
`timescale 1ns/10ps

module fxp_resize import fxp_pkg::*; #(
    parameter int IN_INT_W   = FXP_INT_W,
    parameter int IN_FRAC_W  = FXP_FRAC_W,
    parameter int OUT_INT_W  = FXP_INT_W,
    parameter int OUT_FRAC_W = FXP_FRAC_W,
    parameter bit ROUND_EN   = 1'b1
) (
    input  logic [IN_INT_W+IN_FRAC_W-1:0]   in_value,
    output logic [OUT_INT_W+OUT_FRAC_W-1:0] out_value,
    output logic                            overflow
);

    localparam int IN_W  = IN_INT_W + IN_FRAC_W;
    localparam int OUT_W = OUT_INT_W + OUT_FRAC_W;
    // Input integer part with output fraction part
    localparam int MID_W = IN_INT_W + OUT_FRAC_W;

    localparam logic [MID_W-1:0] MID_MAX = {1'b0, {(MID_W-1){1'b1}}};
    localparam logic [OUT_W-1:0] SAT_POS = {1'b0, {(OUT_W-1){1'b1}}};
    localparam logic [OUT_W-1:0] SAT_NEG = {1'b1, {(OUT_W-1){1'b0}}};

    logic [MID_W-1:0] mid_value;

    // ----------------------------------------
    // Fraction bits
    // ----------------------------------------
    if (OUT_FRAC_W < IN_FRAC_W) begin : g_drop_frac
        localparam int DROP_W = IN_FRAC_W - OUT_FRAC_W;
        logic [MID_W-1:0] kept;
        logic             half_bit;

        assign kept     = in_value[IN_W-1:DROP_W];
        assign half_bit = ROUND_EN && in_value[DROP_W-1];
        // The largest positive value is never rounded up, it would wrap
        assign mid_value = (half_bit && kept != MID_MAX) ? kept + 1'b1 : kept;
    end else if (OUT_FRAC_W == IN_FRAC_W) begin : g_keep_frac
        assign mid_value = in_value;
    end else begin : g_pad_frac
        assign mid_value = {in_value, {(OUT_FRAC_W-IN_FRAC_W){1'b0}}};
    end

    // ----------------------------------------
    // Integer bits
    // ----------------------------------------
    if (OUT_INT_W < IN_INT_W) begin : g_drop_int
        // Bits that must all equal the sign for the value to fit
        logic [IN_INT_W-OUT_INT_W:0] top_bits;

        assign top_bits = mid_value[MID_W-1:OUT_W-1];

        always_comb begin
            if (!mid_value[MID_W-1] && |top_bits) begin
                out_value = SAT_POS;
                overflow  = 1'b1;
            end else if (mid_value[MID_W-1] && !(&top_bits)) begin
                out_value = SAT_NEG;
                overflow  = 1'b1;
            end else begin
                out_value = mid_value[OUT_W-1:0];
                overflow  = 1'b0;
            end
        end
    end else begin : g_extend_int
        assign out_value = OUT_W'($signed(mid_value));
        assign overflow  = 1'b0;
    end

    // A flagged result always sits on one of the two limits
    always_comb begin
        assert (!overflow || out_value == SAT_POS || out_value == SAT_NEG)
            else $error("resize overflow with unsaturated output %h", out_value);
    end

endmodule

/* logic/fxp_result_align.sv */
// Latency alignment of add/sub and multiply results and output select
`timescale 1ns/10ps

module fxp_result_align import fxp_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  fxp_op_e op,
    input  fxp_t    addsub_value,
    input  logic    addsub_ovf,
    input  fxp_t    mul_value,
    input  logic    mul_ovf,
    input  fxp_t    div_value,
    input  logic    div_ovf,
    output fxp_t    result,
    output logic    overflow
);

    // Add/sub is combinational, so it waits the whole divider latency
    localparam int AS_DEPTH  = DIV_LAT;
    localparam int MUL_DEPTH = DIV_LAT - MUL_LAT;

    // Flag in the top bit, value below
    fxp_op_e        op_dly  [AS_DEPTH];
    logic [FXP_W:0] as_dly  [AS_DEPTH];
    logic [FXP_W:0] mul_dly [MUL_DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < AS_DEPTH; i++) begin
                op_dly[i] <= OP_ADD;
                as_dly[i] <= '0;
            end
            for (int i = 0; i < MUL_DEPTH; i++) begin
                mul_dly[i] <= '0;
            end
        end else begin
            op_dly[0]  <= op;
            as_dly[0]  <= {addsub_ovf, addsub_value};
            mul_dly[0] <= {mul_ovf, mul_value};
            for (int i = 1; i < AS_DEPTH; i++) begin
                op_dly[i] <= op_dly[i-1];
                as_dly[i] <= as_dly[i-1];
            end
            for (int i = 1; i < MUL_DEPTH; i++) begin
                mul_dly[i] <= mul_dly[i-1];
            end
        end
    end

    // Pick the unit that matches the op issued DIV_LAT cycles ago
    always_comb begin
        case (op_dly[AS_DEPTH-1])
            OP_ADD, OP_SUB: {overflow, result} = as_dly[AS_DEPTH-1];
            OP_MUL:         {overflow, result} = mul_dly[MUL_DEPTH-1];
            default:        {overflow, result} = {div_ovf, div_value};
        endcase
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fxp_arith_unit testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fxp_arith_unit \
    -f fxp_arith_unit.f \
    -o sim_fxp_arith_unit

./obj_dir/sim_fxp_arith_unit | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished, no failure in $LOG"

/* tb/fxp_arith_checker.sv */
// Testbench checker: input capture, reference model, result compare, per-test summary
`timescale 1ns/10ps

module fxp_arith_checker import fxp_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  fxp_t    a,
    input  fxp_t    b,
    input  fxp_op_e op,
    input  int      test_id,
    input  fxp_t    result,
    input  logic    overflow,
    output int      tests_done,
    output int      tests_failed,
    output int      errors
);

    localparam int MAX_RAW = 2 ** (FXP_W - 1) - 1;
    localparam int MIN_RAW = -(2 ** (FXP_W - 1));

    typedef struct packed {
        fxp_t    a;
        fxp_t    b;
        fxp_op_e op;
        int      id;
        int      edge_idx;
    } sample_t;

    sample_t pending[$];
    int      edge_cnt;
    int      last_id;
    int      done_cnt;
    int      failed_cnt;
    int      err_cnt;
    int      checks [8];
    int      misses [8];

    assign tests_done   = done_cnt;
    assign tests_failed = failed_cnt;
    assign errors       = err_cnt;

    function automatic string test_name(int id);
        case (id)
            1:       return "reset";
            2:       return "add_sub";
            3:       return "multiply";
            4:       return "divide";
            5:       return "mixed";
            default: return "idle";
        endcase
    endfunction

    // ----------------------------------------
    // Reference model, {overflow, value}
    // ----------------------------------------
    function automatic logic [FXP_W:0] predict_result(fxp_t x, fxp_t y, fxp_op_e code);
        int   sa;
        int   sb;
        int   full;
        int   mag_a;
        int   mag_b;
        int   quo;
        int   rem;
        logic neg;
        sa = $signed(x);
        sb = $signed(y);
        case (code)
            OP_ADD: full = sa + sb;
            OP_SUB: full = sa - sb;
            // Half an LSB then floor, ties toward plus infinity
            OP_MUL: full = (sa * sb + (1 << (FXP_FRAC_W - 1))) >>> FXP_FRAC_W;
            default: begin
                mag_a = (sa < 0) ? -sa : sa;
                mag_b = (sb < 0) ? -sb : sb;
                neg   = (sa < 0) != (sb < 0);
                if (mag_a == 0) begin
                    return '0;
                end
                if (mag_b == 0) begin
                    return neg ? {1'b1, FXP_MIN} : {1'b1, FXP_MAX};
                end
                quo = (mag_a << FXP_FRAC_W) / mag_b;
                rem = (mag_a << FXP_FRAC_W) % mag_b;
                // Round the magnitude, ties away from zero
                if (rem != 0 && 2 * rem >= mag_b) begin
                    quo++;
                end
                full = neg ? -quo : quo;
            end
        endcase
        if (full > MAX_RAW) begin
            return {1'b1, FXP_MAX};
        end
        if (full < MIN_RAW) begin
            return {1'b1, FXP_MIN};
        end
        return {1'b0, full[FXP_W-1:0]};
    endfunction

    task automatic check_value(int id, string what, logic [FXP_W:0] want, logic [FXP_W:0] got);
        checks[id]++;
        if (got !== want) begin
            misses[id]++;
            err_cnt++;
            $display("FAIL %s: %s expected %h ovf %b, actual %h ovf %b", test_name(id), what,
                     want[FXP_W-1:0], want[FXP_W], got[FXP_W-1:0], got[FXP_W]);
        end
    endtask

    task automatic report_test(int id);
        if (id != 0) begin
            $display("%s finished: %0d checks, %0d mismatches", test_name(id), checks[id],
                     misses[id]);
            done_cnt++;
            if (misses[id] > 0) begin
                failed_cnt++;
            end
        end
    endtask

    // Inputs are stable at the rising edge
    always @(posedge clk) begin
        if (!rstn) begin
            edge_cnt = 0;
            pending.delete();
        end else begin
            edge_cnt = edge_cnt + 1;
            pending.push_back(sample_t'{a: a, b: b, op: op, id: test_id, edge_idx: edge_cnt});
        end
    end

    // Outputs are compared mid-cycle, the sampling edge counts as the first of UNIT_LAT
    always @(negedge clk) begin
        sample_t s;
        fxp_op_e code;
        if (pending.size() > 0 && pending[0].edge_idx + UNIT_LAT - 1 == edge_cnt) begin
            s    = pending.pop_front();
            code = s.op;
            if (s.id != last_id) begin
                report_test(last_id);
                last_id = s.id;
            end
            check_value(s.id, $sformatf("%s a=%h b=%h", code.name(), s.a, s.b),
                        predict_result(s.a, s.b, code), {overflow, result});
        end else if (!rstn || edge_cnt < UNIT_LAT) begin
            check_value(test_id, "output before first result", '0, {overflow, result});
        end
    end

endmodule

/* tb/tb_fxp_arith_unit.sv */
// Testbench top: clock, reset, LCG stimulus, test sequence and watchdog
`timescale 1ns/10ps

module tb_fxp_arith_unit import fxp_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int RESET_OPS    = UNIT_LAT + 4;
    localparam int N_RANDOM     = 64;
    localparam int N_MIXED      = 100;
    localparam int N_AS_DIR     = 6;
    localparam int N_MUL_DIR    = 7;
    localparam int N_DIV_DIR    = 10;
    localparam int N_TESTS      = 5;
    // Reset, every test, and one idle issue at the end
    localparam int TOTAL_OPS = RESET_CYCLES + RESET_OPS + 3 * N_RANDOM + N_AS_DIR
                             + N_MUL_DIR + N_DIV_DIR + N_MIXED + 1;

    logic        clk = 1'b0;
    logic        rstn;
    fxp_t        a;
    fxp_t        b;
    fxp_op_e     op;
    fxp_t        result;
    logic        overflow;
    int          test_id;
    int          cur_test;
    int          tests_done;
    int          tests_failed;
    int          errors;
    logic [31:0] rng_state;

    // Saturation both ways, then one in range
    fxp_t    as_dir_a  [N_AS_DIR] = '{16'h7000, 16'h8000, 16'h7FFF, 16'h8000, 16'h0000, 16'h7FFF};
    fxp_t    as_dir_b  [N_AS_DIR] = '{16'h2000, 16'hF000, 16'h8000, 16'h0001, 16'h8000, 16'h0000};
    fxp_op_e as_dir_op [N_AS_DIR] = '{OP_ADD, OP_ADD, OP_SUB, OP_SUB, OP_SUB, OP_ADD};
    // Ties, underflow to zero, large products, exact -128.0
    fxp_t mul_dir_a [N_MUL_DIR] = '{16'h0001, 16'hFFFF, 16'h0001, 16'h7FFF, 16'h8000,
                                    16'h8000, 16'h8000};
    fxp_t mul_dir_b [N_MUL_DIR] = '{16'h0080, 16'h0080, 16'h0001, 16'h7FFF, 16'h8000,
                                    16'h7FFF, 16'h0100};
    // Ties, exact -128.0, +128.0, divide by zero, zero dividend
    fxp_t div_dir_a [N_DIV_DIR] = '{16'h0001, 16'hFFFF, 16'h8000, 16'h4000, 16'h8000,
                                    16'h0100, 16'hFF00, 16'h0000, 16'h0000, 16'h0000};
    fxp_t div_dir_b [N_DIV_DIR] = '{16'h0200, 16'h0200, 16'h0100, 16'hFF80, 16'hFF00,
                                    16'h0000, 16'h0000, 16'h0300, 16'h0000, 16'hFD00};

    always #(CLK_PERIOD / 2) clk = ~clk;

    fxp_arith_unit u_dut (
        .clk      (clk),
        .rstn     (rstn),
        .a        (a),
        .b        (b),
        .op       (op),
        .result   (result),
        .overflow (overflow)
    );

    fxp_arith_checker u_checker (
        .clk          (clk),
        .rstn         (rstn),
        .a            (a),
        .b            (b),
        .op           (op),
        .test_id      (test_id),
        .result       (result),
        .overflow     (overflow),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .errors       (errors)
    );

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output fxp_t v);
        rng_state = lcg_step(rng_state);
        v = rng_state[31:16];
    endtask

    // One operation per cycle, driven on the falling edge
    task automatic issue(fxp_t a_v, fxp_t b_v, fxp_op_e op_v);
        @(negedge clk);
        a       <= a_v;
        b       <= b_v;
        op      <= op_v;
        test_id <= cur_test;
    endtask

    initial begin
        fxp_t    ra;
        fxp_t    rb;
        fxp_t    rsel;
        fxp_op_e rop;
        rng_state = 32'h60caa2f6;
        rstn      = 1'b0;
        a         = '0;
        b         = '0;
        op        = OP_ADD;
        cur_test  = 1;
        test_id   = 1;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn <= 1'b1;
        repeat (RESET_OPS) issue('0, '0, OP_ADD);

        cur_test = 2;
        for (int i = 0; i < N_RANDOM; i++) begin
            next_random(ra);
            next_random(rb);
            issue(ra, rb, (i % 2 == 1) ? OP_SUB : OP_ADD);
        end
        for (int i = 0; i < N_AS_DIR; i++) issue(as_dir_a[i], as_dir_b[i], as_dir_op[i]);

        // Every other operand scaled down to keep some products in range
        cur_test = 3;
        for (int i = 0; i < N_RANDOM; i++) begin
            next_random(ra);
            next_random(rb);
            issue(ra, (i % 2 == 1) ? fxp_t'($signed(rb) >>> 4) : rb, OP_MUL);
        end
        for (int i = 0; i < N_MUL_DIR; i++) issue(mul_dir_a[i], mul_dir_b[i], OP_MUL);

        cur_test = 4;
        for (int i = 0; i < N_RANDOM; i++) begin
            next_random(ra);
            next_random(rb);
            while (rb == '0) next_random(rb);
            issue((i % 2 == 1) ? fxp_t'($signed(ra) >>> 6) : ra, rb, OP_DIV);
        end
        for (int i = 0; i < N_DIV_DIR; i++) issue(div_dir_a[i], div_dir_b[i], OP_DIV);

        // Op code differs from the previous one on every cycle
        cur_test = 5;
        rop      = OP_DIV;
        for (int i = 0; i < N_MIXED; i++) begin
            next_random(ra);
            next_random(rb);
            next_random(rsel);
            rop = fxp_op_e'(2'(rop + 1 + rsel % 3));
            issue(ra, rb, rop);
        end

        cur_test = 0;
        issue('0, '0, OP_ADD);
        wait (tests_done == N_TESTS);
        $display("Tests passed %0d, tests with mismatches %0d, total mismatches %0d",
                 N_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (TOTAL_OPS + UNIT_LAT + 50));
        $display("Simulation timed out with %0d of %0d tests finished", tests_done, N_TESTS);
        $display("TEST FAILED");
        $finish;
    end

endmodule
